// ==== common/psram_pkg.sv ====
// Shared constants and types for the lockstep quad-SPI PSRAM controller
// Every module refers to these by scoped name (psram_pkg::name)
package psram_pkg;

    localparam int NUM_DEVICES  = 3;    // PSRAMs driven in lockstep
    localparam int ADDR_WIDTH   = 23;
    localparam int WORD_WIDTH   = 16;   // One word per device per frame
    localparam int NIBBLE_WIDTH = 4;    // SIO bus width
    localparam int ADDR_NIBBLES = 6;    // 24-bit address on the bus, top bit padded
    localparam int WORD_NIBBLES = WORD_WIDTH / NIBBLE_WIDTH;
    localparam int CYCLE_WIDTH  = 5;    // Enough for a 20-cycle read frame

    // Power-up wait before the device clock may run
    localparam int INIT_DELAY_CYCLES = 12800;
    localparam int INIT_CNT_WIDTH    = $clog2(INIT_DELAY_CYCLES);
    localparam logic [INIT_CNT_WIDTH-1:0] INIT_LAST_COUNT = INIT_CNT_WIDTH'(INIT_DELAY_CYCLES - 1);

    // Command bytes
    localparam logic [7:0] CMD_RSTEN     = 8'h66;
    localparam logic [7:0] CMD_RST       = 8'h99;
    localparam logic [7:0] CMD_ENTER_QPI = 8'h35;
    localparam logic [7:0] CMD_QPI_READ  = 8'hEB;
    localparam logic [7:0] CMD_QPI_WRITE = 8'h38;

    // Frame layout, cycle index counted from 0 at mem_ce fall
    localparam logic [CYCLE_WIDTH-1:0] SPI_LAST_CYCLE    = 5'd7;
    localparam logic [CYCLE_WIDTH-1:0] ADDR_FIRST_CYCLE  = 5'd2;   // After two cmd nibbles
    localparam logic [CYCLE_WIDTH-1:0] WDATA_FIRST_CYCLE = 5'd8;
    localparam logic [CYCLE_WIDTH-1:0] WRITE_LAST_CYCLE  = 5'd11;
    localparam logic [CYCLE_WIDTH-1:0] RDATA_FIRST_CYCLE = 5'd15;  // After the wait cycles
    localparam logic [CYCLE_WIDTH-1:0] RDATA_LAST_CYCLE  = 5'd18;
    localparam logic [CYCLE_WIDTH-1:0] READ_LAST_CYCLE   = 5'd19;

    // User operation code, 0 and 3 are ignored
    typedef enum logic [1:0] {
        OP_NONE     = 2'd0,
        OP_WRITE    = 2'd1,
        OP_READ     = 2'd2,
        OP_RESERVED = 2'd3
    } psram_op_e;

    typedef enum logic [1:0] {
        FRAME_IDLE,
        FRAME_SPI,     // Init command, one bit per cycle on SIO0
        FRAME_WRITE,
        FRAME_READ
    } psram_frame_e;

    // One command byte, serial in SPI mode and nibble-wide in QPI mode
    typedef union packed {
        logic [7:0]                   bits;     // bits[7] goes out first
        logic [1:0][NIBBLE_WIDTH-1:0] nibbles;  // nibbles[1] goes out first
    } psram_cmd_u;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0]                  addr;
        psram_op_e                              op;
        logic [NUM_DEVICES-1:0][WORD_WIDTH-1:0] wdata;  // Index is the device
    } psram_req_t;

    typedef struct packed {
        psram_frame_e           kind;
        logic [CYCLE_WIDTH-1:0] cycle;
    } psram_phase_t;

    // Pin-side view of one SIO bus
    typedef struct packed {
        logic [NIBBLE_WIDTH-1:0] dout;
        logic                    oe;
    } psram_bus_t;

endpackage

// ==== design/psram_engine/psram_frame_counter.sv ====
// Frame timing for all three devices
// Starts an SPI, write or read frame on spi_go or accept, counts the
// cycle index up to the last cycle of that kind, and drives mem_ce,
// busy and a one-cycle frame_done when the frame closes
`timescale 1ns/100ps

module psram_frame_counter (
    input  logic                    clk_PSRAM,
    input  logic                    reset,
    input  logic                    spi_go,
    input  logic                    accept,
    input  psram_pkg::psram_op_e    op,
    output psram_pkg::psram_phase_t phase,
    output logic                    busy,
    output logic                    frame_done,
    output logic                    mem_ce
);

    logic [psram_pkg::CYCLE_WIDTH-1:0] last_cycle;  // Last index of the running frame

    always_comb begin
        case (phase.kind)
            psram_pkg::FRAME_SPI:   last_cycle = psram_pkg::SPI_LAST_CYCLE;
            psram_pkg::FRAME_WRITE: last_cycle = psram_pkg::WRITE_LAST_CYCLE;
            default:                last_cycle = psram_pkg::READ_LAST_CYCLE;
        endcase
    end

    assign busy = (phase.kind != psram_pkg::FRAME_IDLE);

    always_ff @(posedge clk_PSRAM) begin
        if (reset) begin
            phase.kind  <= psram_pkg::FRAME_IDLE;
            phase.cycle <= '0;
            frame_done  <= 1'b0;
            mem_ce      <= 1'b1;   // Active low, deselected
        end else begin
            frame_done <= 1'b0;
            if (!busy) begin
                if (spi_go) begin
                    // Init command, only seen before qpi_on
                    phase.kind  <= psram_pkg::FRAME_SPI;
                    phase.cycle <= '0;
                    mem_ce      <= 1'b0;
                end else if (accept) begin
                    phase.kind  <= (op == psram_pkg::OP_WRITE) ? psram_pkg::FRAME_WRITE
                                                               : psram_pkg::FRAME_READ;
                    phase.cycle <= '0;
                    mem_ce      <= 1'b0;
                end
            end else if (phase.cycle == last_cycle) begin
                phase.kind  <= psram_pkg::FRAME_IDLE;   // Close the frame
                phase.cycle <= '0;
                mem_ce      <= 1'b1;
                frame_done  <= 1'b1;                    // Same clock as mem_ce rise
            end else begin
                phase.cycle <= phase.cycle + 1'b1;
            end
        end
    end

    // Chip enable tracks the frame exactly
    ce_matches_busy: assert property (
        @(posedge clk_PSRAM) disable iff (reset)
        mem_ce == !busy
    );

    frame_done_single: assert property (
        @(posedge clk_PSRAM) disable iff (reset)
        frame_done |=> !frame_done
    );

endmodule

// ==== design/psram_engine/psram_sio_io.sv ====
// Bus side of the frame engine
// Decodes the nibble and output enable of each SIO bus from the
// registered frame phase, and shifts the read nibbles into one word
// per device during the data cycles of a read frame
`timescale 1ns/100ps

module psram_sio_io (
    input  logic                    clk_PSRAM,
    input  logic                    reset,
    input  psram_pkg::psram_phase_t phase,
    input  psram_pkg::psram_cmd_u   cmd,
    input  psram_pkg::psram_req_t   req,
    input  logic [psram_pkg::NUM_DEVICES-1:0][psram_pkg::NIBBLE_WIDTH-1:0] sio_in,
    output psram_pkg::psram_bus_t [psram_pkg::NUM_DEVICES-1:0] bus_out,
    output logic [psram_pkg::NUM_DEVICES-1:0][psram_pkg::WORD_WIDTH-1:0] rdata
);

    psram_pkg::psram_cmd_u qpi_cmd;    // EBh or 38h, sent as nibbles
    logic [psram_pkg::ADDR_NIBBLES-1:0][psram_pkg::NIBBLE_WIDTH-1:0] addr_nib;
    logic [psram_pkg::NUM_DEVICES-1:0][psram_pkg::WORD_NIBBLES-1:0]
          [psram_pkg::NIBBLE_WIDTH-1:0] wdata_nib;
    logic [psram_pkg::CYCLE_WIDTH-1:0] bit_step;    // Serial bit index, MSB first
    logic [psram_pkg::CYCLE_WIDTH-1:0] addr_step;   // Address nibbles still to go
    logic [psram_pkg::CYCLE_WIDTH-1:0] data_step;   // Write nibbles still to go
    logic [psram_pkg::NUM_DEVICES-1:0] oe_vec;
    logic                              rd_window;   // Device owns the bus

    assign addr_nib  = {1'b0, req.addr};   // Pad to 24 bits
    assign wdata_nib = req.wdata;

    assign bit_step  = psram_pkg::SPI_LAST_CYCLE - phase.cycle;
    assign addr_step = psram_pkg::WDATA_FIRST_CYCLE - phase.cycle - 5'd1;
    assign data_step = psram_pkg::WRITE_LAST_CYCLE - phase.cycle;

    assign rd_window = (phase.kind == psram_pkg::FRAME_READ) &&
                       (phase.cycle >= psram_pkg::RDATA_FIRST_CYCLE) &&
                       (phase.cycle <= psram_pkg::RDATA_LAST_CYCLE);

    // Bus decode, all inputs come from registers
    always_comb begin
        qpi_cmd.bits = (phase.kind == psram_pkg::FRAME_READ) ? psram_pkg::CMD_QPI_READ
                                                             : psram_pkg::CMD_QPI_WRITE;
        for (int d = 0; d < psram_pkg::NUM_DEVICES; d++) begin
            bus_out[d].dout = '0;
            bus_out[d].oe   = 1'b0;
            case (phase.kind)
                psram_pkg::FRAME_SPI: begin
                    // Serial command on SIO0, other lines held low
                    bus_out[d].dout = {{(psram_pkg::NIBBLE_WIDTH-1){1'b0}},
                                       cmd.bits[bit_step[2:0]]};
                    bus_out[d].oe   = 1'b1;
                end
                psram_pkg::FRAME_WRITE, psram_pkg::FRAME_READ: begin
                    if (phase.cycle < psram_pkg::ADDR_FIRST_CYCLE) begin
                        bus_out[d].dout = qpi_cmd.nibbles[~phase.cycle[0]];  // High first
                        bus_out[d].oe   = 1'b1;
                    end else if (phase.cycle < psram_pkg::WDATA_FIRST_CYCLE) begin
                        bus_out[d].dout = addr_nib[addr_step[2:0]];
                        bus_out[d].oe   = 1'b1;
                    end else if (phase.kind == psram_pkg::FRAME_WRITE) begin
                        bus_out[d].dout = wdata_nib[d][data_step[1:0]];
                        bus_out[d].oe   = 1'b1;
                    end
                    // Read frames release the bus after the address
                end
                default: ;
            endcase
            oe_vec[d] = bus_out[d].oe;
        end
    end

    // Read word assembly, high nibble arrives first
    always_ff @(posedge clk_PSRAM) begin
        if (reset) begin
            rdata <= '0;
        end else if (rd_window) begin
            for (int d = 0; d < psram_pkg::NUM_DEVICES; d++) begin
                rdata[d] <= {rdata[d][psram_pkg::WORD_WIDTH-psram_pkg::NIBBLE_WIDTH-1:0],
                             sio_in[d]};
            end
        end
    end

    // No contention with the devices while they drive read data
    no_drive_in_read: assert property (
        @(posedge clk_PSRAM) disable iff (reset)
        rd_window |-> (oe_vec == '0)
    );

endmodule

// ==== design/psram_init/psram_init_sequencer.sv ====
// Power-up sequencer for the PSRAM devices
// Keeps the device clock off for the start-up delay, then issues the
// SPI commands reset-enable, reset and enter-QPI, one frame each,
// and finally raises qpi_on for the user side
`timescale 1ns/100ps

module psram_init_sequencer (
    input  logic                  clk_PSRAM,
    input  logic                  reset,
    input  logic                  frame_done,
    output logic                  spi_go,
    output psram_pkg::psram_cmd_u cmd,
    output logic                  mem_clk_en,
    output logic                  qpi_on
);

    typedef enum logic [2:0] {
        ST_DELAY,       // Clock held off
        ST_RSTEN,
        ST_RST,
        ST_ENTER_QPI,
        ST_READY        // QPI mode, user frames allowed
    } init_state_e;

    init_state_e                              state;
    logic [psram_pkg::INIT_CNT_WIDTH-1:0]     delay_cnt;

    always_ff @(posedge clk_PSRAM) begin
        if (reset) begin
            state     <= ST_DELAY;
            delay_cnt <= '0;
            spi_go    <= 1'b0;
            qpi_on    <= 1'b0;
        end else begin
            spi_go <= 1'b0;    // One-cycle pulse
            case (state)
                ST_DELAY: begin
                    if (delay_cnt == psram_pkg::INIT_LAST_COUNT) begin
                        state  <= ST_RSTEN;
                        spi_go <= 1'b1;    // First command right away
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                ST_RSTEN: begin
                    if (frame_done) begin
                        state  <= ST_RST;
                        spi_go <= 1'b1;
                    end
                end
                ST_RST: begin
                    if (frame_done) begin
                        state  <= ST_ENTER_QPI;
                        spi_go <= 1'b1;
                    end
                end
                ST_ENTER_QPI: begin
                    if (frame_done) begin
                        state  <= ST_READY;
                        qpi_on <= 1'b1;    // One clock after last frame_done
                    end
                end
                default: ;                 // READY is terminal
            endcase
        end
    end

    // Command byte follows the state, so it holds through the frame
    always_comb begin
        case (state)
            ST_RSTEN:     cmd.bits = psram_pkg::CMD_RSTEN;
            ST_RST:       cmd.bits = psram_pkg::CMD_RST;
            ST_ENTER_QPI: cmd.bits = psram_pkg::CMD_ENTER_QPI;
            default:      cmd.bits = 8'h00;
        endcase
    end

    assign mem_clk_en = (state != ST_DELAY);   // Device clock off only in delay

    // Once in QPI mode the device never goes back to SPI
    qpi_on_sticky: assert property (
        @(posedge clk_PSRAM) disable iff (reset)
        qpi_on |=> qpi_on
    );

endmodule

// ==== design/psram_request_latch.sv ====
// Input side of the controller
// Qualifies quad_start against qpi_on, busy and the op code, and holds
// the address, op and write words of the accepted frame
`timescale 1ns/100ps

module psram_request_latch (
    input  logic                          clk_PSRAM,
    input  logic                          reset,
    input  logic                          quad_start,
    input  psram_pkg::psram_op_e          read_write,
    input  logic [psram_pkg::ADDR_WIDTH-1:0] address,
    input  logic [psram_pkg::NUM_DEVICES-1:0][psram_pkg::WORD_WIDTH-1:0] data_in,
    input  logic                          qpi_on,
    input  logic                          busy,
    output logic                          accept,
    output psram_pkg::psram_req_t         req
);

    logic op_valid;    // Only read and write start a frame

    assign op_valid = (read_write == psram_pkg::OP_READ) ||
                      (read_write == psram_pkg::OP_WRITE);

    // Same-cycle strobe ignored while busy or before init is done
    assign accept = quad_start && qpi_on && !busy && op_valid;

    // Payload held until the next accept
    always_ff @(posedge clk_PSRAM) begin
        if (accept) begin
            req.addr  <= address;
            req.op    <= read_write;
            req.wdata <= data_in;
        end
    end

    // An accepted request starts the engine on the next clock
    accept_starts_frame: assert property (
        @(posedge clk_PSRAM) disable iff (reset)
        accept |=> busy
    );

endmodule

// ==== design/psram_top.sv ====
// Top level of the three-device quad-SPI PSRAM controller
// Connects the request latch, the init sequencer and the frame engine
// to the user interface and the split SIO pins
`timescale 1ns/100ps

module psram_top (
    input  logic                             clk_PSRAM,
    input  logic                             reset,
    input  logic                             quad_start,
    input  psram_pkg::psram_op_e             read_write,
    input  logic [psram_pkg::ADDR_WIDTH-1:0] address,
    input  logic [psram_pkg::NUM_DEVICES-1:0][psram_pkg::WORD_WIDTH-1:0]   data_in,
    input  logic [psram_pkg::NUM_DEVICES-1:0][psram_pkg::NIBBLE_WIDTH-1:0] sio_in,
    output logic [psram_pkg::NUM_DEVICES-1:0][psram_pkg::WORD_WIDTH-1:0]   data_out,
    output psram_pkg::psram_bus_t [psram_pkg::NUM_DEVICES-1:0]             sio_out,
    output logic                             mem_ce,
    output logic                             mem_clk_en,
    output logic                             qpi_on,
    output logic                             endcommand
);

    logic                    accept;
    psram_pkg::psram_req_t   req;
    logic                    spi_go;
    psram_pkg::psram_cmd_u   cmd;
    psram_pkg::psram_phase_t phase;
    logic                    busy;
    logic                    frame_done;   // Also the user end strobe

    assign endcommand = frame_done;

    psram_request_latch psram_request_latch_inst (
        .clk_PSRAM  (clk_PSRAM),
        .reset      (reset),
        .quad_start (quad_start),
        .read_write (read_write),
        .address    (address),
        .data_in    (data_in),
        .qpi_on     (qpi_on),
        .busy       (busy),
        .accept     (accept),
        .req        (req)
    );

    psram_init_sequencer psram_init_sequencer_inst (
        .clk_PSRAM  (clk_PSRAM),
        .reset      (reset),
        .frame_done (frame_done),
        .spi_go     (spi_go),
        .cmd        (cmd),
        .mem_clk_en (mem_clk_en),
        .qpi_on     (qpi_on)
    );

    // Frame kind comes from the live op, as accept is same-cycle
    psram_frame_counter psram_frame_counter_inst (
        .clk_PSRAM  (clk_PSRAM),
        .reset      (reset),
        .spi_go     (spi_go),
        .accept     (accept),
        .op         (read_write),
        .phase      (phase),
        .busy       (busy),
        .frame_done (frame_done),
        .mem_ce     (mem_ce)
    );

    psram_sio_io psram_sio_io_inst (
        .clk_PSRAM  (clk_PSRAM),
        .reset      (reset),
        .phase      (phase),
        .cmd        (cmd),
        .req        (req),
        .sio_in     (sio_in),
        .bus_out    (sio_out),
        .rdata      (data_out)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the run from the simulation log
verilator --binary --timing --assert --top-module psram_tb -f sources.f -o psram_sim \
    && ./obj_dir/psram_sim > sim.log 2>&1 \
    ; cat sim.log \
    && ! grep -q "TEST FAILED" sim.log \
    && grep -q "TEST OK" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== sources.f ====
common/psram_pkg.sv
design/psram_request_latch.sv
design/psram_init/psram_init_sequencer.sv
design/psram_engine/psram_frame_counter.sv
design/psram_engine/psram_sio_io.sv
design/psram_top.sv
tests/psram_device_model.sv
tests/psram_tb.sv

// ==== tests/psram_device_model.sv ====
// Behavioural model of one quad-SPI PSRAM on a split SIO bus
// Decodes the SPI init bytes and the QPI write and read frames on the
// falling clock edge, keeps its own memory and drives read nibbles
`timescale 1ns/100ps

module psram_device_model (
    input  logic                  clk_PSRAM,
    input  logic                  mem_ce,
    input  logic                  mem_clk_en,
    input  psram_pkg::psram_bus_t bus,
    output logic [3:0]            sio_drive,
    output logic [2:0][7:0]       spi_log,      // Init bytes in arrival order
    output int                    spi_frames,
    output int                    frame_count,  // All mem_ce falls
    output int                    last_len,     // Cycles of the last frame
    output logic [22:0]           last_wr_addr,
    output logic [15:0]           last_wr_word,
    output int                    fault_count
);

    localparam logic [7:0] ENTER_QPI_CMD = 8'h35;
    localparam logic [7:0] QPI_WRITE_CMD = 8'h38;
    localparam logic [7:0] QPI_READ_CMD  = 8'hEB;

    logic [15:0] mem [logic [22:0]];   // Never written reads as zero
    logic        qpi_mode;
    logic        active;
    int          cyc;                  // Cycle index in the frame
    logic [7:0]  cmd_byte;
    logic [23:0] addr_sh;
    logic [15:0] word_sh;
    logic [15:0] rd_word;
    logic        want_oe;

    task automatic flag_error(input string what);
        fault_count++;
        $display("Device model %m: %s in frame cycle %0d", what, cyc);
    endtask

    initial begin
        sio_drive    = '0;
        spi_log      = '0;
        spi_frames   = 0;
        frame_count  = 0;
        last_len     = 0;
        last_wr_addr = '0;
        last_wr_word = '0;
        fault_count  = 0;
        qpi_mode     = 1'b0;
        active       = 1'b0;
        cyc          = 0;
        cmd_byte     = '0;
        addr_sh      = '0;
        word_sh      = '0;
        rd_word      = '0;
    end

    always @(negedge clk_PSRAM) begin
        sio_drive = '0;   // Only driven in the read data cycles
        if (!mem_ce) begin
            cyc    = active ? cyc + 1 : 0;
            active = 1'b1;
            if (!mem_clk_en)
                flag_error("frame while the device clock is off");
            if (!qpi_mode) begin
                cmd_byte = {cmd_byte[6:0], bus.dout[0]};   // Serial bits MSB first
            end else if (cyc < 2) begin
                cmd_byte = {cmd_byte[3:0], bus.dout};
            end else if (cyc < 8) begin
                addr_sh = {addr_sh[19:0], bus.dout};
            end else if (cmd_byte == QPI_WRITE_CMD) begin
                word_sh = {word_sh[11:0], bus.dout};
            end
            // Controller owns the bus for cmd and address, and write data
            want_oe = (cyc < 8) || (qpi_mode && cmd_byte == QPI_WRITE_CMD);
            if (bus.oe != want_oe)
                flag_error("output enable wrong for this cycle");
            if (qpi_mode && cmd_byte == QPI_READ_CMD) begin
                if (cyc == 8)
                    rd_word = mem.exists(addr_sh[22:0]) ? mem[addr_sh[22:0]] : 16'h0000;
                if (cyc >= 15 && cyc <= 18) begin
                    sio_drive = rd_word[15:12];   // High nibble first
                    rd_word   = rd_word << 4;
                end
            end
        end else if (active) begin
            active      = 1'b0;                   // Frame over once mem_ce is back high
            frame_count++;
            last_len    = cyc + 1;
            if (!qpi_mode) begin
                if (spi_frames < 3)
                    spi_log[spi_frames[1:0]] = cmd_byte;
                else
                    flag_error("more than three SPI commands");
                spi_frames++;
                if (cmd_byte == ENTER_QPI_CMD)
                    qpi_mode = 1'b1;
            end else if (cmd_byte == QPI_WRITE_CMD) begin
                if (addr_sh[23])
                    flag_error("address pad bit is set");
                mem[addr_sh[22:0]] = word_sh;
                last_wr_addr       = addr_sh[22:0];
                last_wr_word       = word_sh;
            end else if (cmd_byte != QPI_READ_CMD) begin
                flag_error("unknown QPI command");
            end
        end
    end

endmodule

// ==== tests/psram_tb.sv ====
// Testbench for the three-device PSRAM controller
// Checks the power-up sequence, ignored requests, then directed and
// LFSR-driven writes and reads against a reference memory
`timescale 1ns/100ps

module psram_tb;

    localparam int POWER_UP_CYCLES = 12800;   // Device clock held off this long
    localparam int NUM_RANDOM_OPS  = 200;
    localparam int TIMEOUT_CYCLES  = POWER_UP_CYCLES + 40 + NUM_RANDOM_OPS * 22;

    logic                  clk_PSRAM;
    logic                  reset;
    logic                  quad_start;
    psram_pkg::psram_op_e  read_write;
    logic [22:0]           address;
    logic [2:0][15:0]      data_in;
    logic [2:0][3:0]       sio_in;
    logic [2:0][15:0]      data_out;
    psram_pkg::psram_bus_t [2:0] sio_out;
    logic                  mem_ce;
    logic                  mem_clk_en;
    logic                  qpi_on;
    logic                  endcommand;

    // Per-device observations from the models
    logic [2:0][7:0] spi_log [3];
    int              spi_frames [3];
    int              frame_count [3];
    int              last_len [3];
    logic [22:0]     last_wr_addr [3];
    logic [15:0]     last_wr_word [3];
    int              fault_count [3];

    logic [15:0] ref_mem [logic [24:0]];   // Key is {device, address}
    logic [15:0] lfsr = 16'd79;
    int          errors = 0;
    int          cycles = 0;

    psram_top psram_top_inst (
        .clk_PSRAM  (clk_PSRAM),
        .reset      (reset),
        .quad_start (quad_start),
        .read_write (read_write),
        .address    (address),
        .data_in    (data_in),
        .sio_in     (sio_in),
        .data_out   (data_out),
        .sio_out    (sio_out),
        .mem_ce     (mem_ce),
        .mem_clk_en (mem_clk_en),
        .qpi_on     (qpi_on),
        .endcommand (endcommand)
    );

    for (genvar g = 0; g < psram_pkg::NUM_DEVICES; g++) begin : dev_gen
        psram_device_model psram_device_model_inst (
            .clk_PSRAM    (clk_PSRAM),
            .mem_ce       (mem_ce),
            .mem_clk_en   (mem_clk_en),
            .bus          (sio_out[g]),
            .sio_drive    (sio_in[g]),
            .spi_log      (spi_log[g]),
            .spi_frames   (spi_frames[g]),
            .frame_count  (frame_count[g]),
            .last_len     (last_len[g]),
            .last_wr_addr (last_wr_addr[g]),
            .last_wr_word (last_wr_word[g]),
            .fault_count  (fault_count[g])
        );
    end

    initial begin
        clk_PSRAM = 1'b0;
        forever #4 clk_PSRAM = ~clk_PSRAM;   // 8 ns period
    end

    always @(posedge clk_PSRAM) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_step(lfsr);            // One step per bit
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // Request that must not start a frame
    task automatic ignored_request(input string name, input psram_pkg::psram_op_e op);
        int frames_before;
        frames_before = frame_count[0];
        quad_start    = 1'b1;
        read_write    = op;
        repeat (6) begin
            @(negedge clk_PSRAM);
            check_value(name, 32'd1, 32'(mem_ce));
        end
        quad_start = 1'b0;
        @(negedge clk_PSRAM);
        check_value(name, frames_before, frame_count[0]);
    endtask

    // One full user frame checked against the reference memory
    task automatic run_frame(input psram_pkg::psram_op_e op, input logic [22:0] addr,
                             input logic [2:0][15:0] words, input logic scramble);
        int          frames_before [3];
        logic [24:0] key;
        logic [15:0] expect_word;
        for (logic [1:0] d = 2'd0; d != 2'd3; d++)
            frames_before[d] = frame_count[d];
        quad_start = 1'b1;
        read_write = op;
        address    = addr;
        data_in    = words;
        if (scramble) begin
            repeat (4) @(negedge clk_PSRAM);   // Engine busy mid-frame
            read_write = (op == psram_pkg::OP_WRITE) ? psram_pkg::OP_READ : psram_pkg::OP_WRITE;
            address    = ~addr;
            data_in    = ~words;
        end
        @(negedge clk_PSRAM);
        while (!endcommand)
            @(negedge clk_PSRAM);
        quad_start = 1'b0;                     // Held until endcommand
        @(negedge clk_PSRAM);
        check_value("endcommand single pulse", 32'd0, 32'(endcommand));
        for (logic [1:0] d = 2'd0; d != 2'd3; d++) begin
            key = {d, addr};
            check_value($sformatf("frames per request, device %0d", d),
                        frames_before[d] + 1, frame_count[d]);
            if (op == psram_pkg::OP_WRITE) begin
                ref_mem[key] = words[d];
                check_value("write frame length", 32'd12, last_len[d]);
                check_value($sformatf("stored address, device %0d", d),
                            32'(addr), 32'(last_wr_addr[d]));
                check_value($sformatf("stored word, device %0d", d),
                            32'(words[d]), 32'(last_wr_word[d]));
            end else begin
                expect_word = ref_mem.exists(key) ? ref_mem[key] : 16'h0000;
                check_value("read frame length", 32'd20, last_len[d]);
                check_value($sformatf("read word, device %0d", d),
                            32'(expect_word), 32'(data_out[d]));
            end
        end
    endtask

    initial begin
        int                   clk_wait;
        int                   dev_faults;
        psram_pkg::psram_op_e op;
        logic [22:0]          addr;
        logic [2:0][15:0]     words;
        reset      = 1'b1;
        quad_start = 1'b0;
        read_write = psram_pkg::OP_NONE;
        address    = '0;
        data_in    = '0;
        repeat (3) @(negedge clk_PSRAM);
        reset = 1'b0;

        // A write request during power-up must be ignored
        quad_start = 1'b1;
        read_write = psram_pkg::OP_WRITE;
        clk_wait   = 0;
        while (!mem_clk_en) begin
            @(negedge clk_PSRAM);
            clk_wait++;
        end
        check_value("mem_clk_en delay", POWER_UP_CYCLES, clk_wait);
        check_value("no frame before init", 32'd0, frame_count[0]);
        quad_start = 1'b0;
        read_write = psram_pkg::OP_NONE;
        while (!qpi_on)
            @(negedge clk_PSRAM);
        for (logic [1:0] d = 2'd0; d != 2'd3; d++) begin
            check_value("SPI frames", 32'd3, spi_frames[d]);
            check_value("reset-enable byte", 32'h66, 32'(spi_log[d][0]));
            check_value("reset byte", 32'h99, 32'(spi_log[d][1]));
            check_value("enter-QPI byte", 32'h35, 32'(spi_log[d][2]));
        end

        ignored_request("op code 0 ignored", psram_pkg::OP_NONE);
        ignored_request("op code 3 ignored", psram_pkg::OP_RESERVED);

        words = {16'hC0DE, 16'hBEEF, 16'h1234};
        run_frame(psram_pkg::OP_READ, 23'h000123, words, 1'b0);    // Unwritten address reads zero
        run_frame(psram_pkg::OP_WRITE, 23'h000123, words, 1'b1);
        run_frame(psram_pkg::OP_READ, 23'h000123, words, 1'b1);

        for (int i = 0; i < NUM_RANDOM_OPS; i++) begin
            op   = rand_bits(1) ? psram_pkg::OP_READ : psram_pkg::OP_WRITE;
            addr = 23'(rand_bits(5)) * 23'h0007B1;  // 32 addresses in the low 16 bits
            for (logic [1:0] d = 2'd0; d != 2'd3; d++)
                words[d] = 16'(rand_bits(16));
            run_frame(op, addr, words, 1'b0);
        end

        @(negedge clk_PSRAM);
        dev_faults = 0;
        for (logic [1:0] d = 2'd0; d != 2'd3; d++)
            dev_faults += fault_count[d];
        $display("Errors: %0d failed checks, %0d device model faults", errors, dev_faults);
        if (errors + dev_faults == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
